// ==== dv/tb_mem_system.sv ====
module tb_mem_system;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REQUESTS = 78;                          // Sum over all six tests
    localparam int REQ_TIMEOUT  = 40;                          // Cycles allowed per request
    localparam int CYCLE_LIMIT  = REQ_TIMEOUT * NUM_REQUESTS;

    logic             clk;
    logic             reset;
    cache_pkg::addr_t addr;
    cache_pkg::word_t data_in;
    logic             rd;
    logic             wr;
    cache_pkg::word_t data_out;
    logic             done;
    logic             stall;
    logic             cache_hit;

    // Processor view of memory, plus per-line tag tracking
    cache_pkg::word_t ref_mem [cache_pkg::MEM_WORDS];
    cache_pkg::tag_t  tag_model [cache_pkg::NUM_LINES];
    bit               line_seen [cache_pkg::NUM_LINES];  // Line holds tag_model entry

    int errors;
    int checks;
    int num_tests;
    int clean_tests;
    int cycle_cnt;
    int seed;

    mem_system u_mem_system (
        .clk       (clk),
        .reset     (reset),
        .addr      (addr),
        .data_in   (data_in),
        .rd        (rd),
        .wr        (wr),
        .data_out  (data_out),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit)
    );

    always #4 clk = ~clk;

    // Whole-run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    function automatic cache_pkg::addr_t make_addr(cache_pkg::tag_t tag, cache_pkg::index_t idx,
                                                   cache_pkg::offset_t off);
        return {tag, idx, off, 1'b0};  // Word aligned byte address
    endfunction

    function automatic logic predict_hit(cache_pkg::addr_t a);
        return line_seen[a[10:3]] && (tag_model[a[10:3]] == a[15:11]);
    endfunction

    task automatic compare_word(string name, cache_pkg::word_t got, cache_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0d ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0d ns: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic invalidate_model();
        for (int i = 0; i < cache_pkg::NUM_LINES; i++) begin
            line_seen[i] = 1'b0;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        invalidate_model();  // Cache comes back empty
    endtask

    // Hold one request until done and sample at the falling edge
    task automatic access(input logic is_wr, input cache_pkg::addr_t a, input cache_pkg::word_t d,
                          output cache_pkg::word_t rdata, output logic hit,
                          output logic first_done);
        int  waited;
        bit  seen;
        waited     = 0;
        seen       = 0;
        rdata      = '0;
        hit        = 1'b0;
        first_done = 1'b0;
        @(posedge clk);
        #1;
        addr    = a;
        data_in = d;
        rd      = !is_wr;
        wr      = is_wr;
        while (!seen && waited < REQ_TIMEOUT) begin
            @(negedge clk);
            if (waited == 0) begin
                first_done = done;  // Hits end in the request cycle
            end
            if (done) begin
                seen  = 1;
                rdata = data_out;
                hit   = cache_hit;
                compare_bit("stall", stall, 1'b0);  // Request ends this cycle
            end else begin
                compare_bit("stall", stall, 1'b1);
            end
            waited++;
        end
        if (!seen) begin
            $display("Request to address %h got no done within %0d cycles", a, REQ_TIMEOUT);
            errors++;
        end
        @(posedge clk);  // Write data lands at this edge
        #1;
        rd = 1'b0;
        wr = 1'b0;
        if (is_wr) begin
            ref_mem[a[15:1]] = d;
        end
        tag_model[a[10:3]] = a[15:11];  // The line holds this tag after a hit or a fill
        line_seen[a[10:3]] = 1'b1;
    endtask

    task automatic read_check(cache_pkg::addr_t a, cache_pkg::word_t exp_data, logic exp_hit);
        cache_pkg::word_t r;
        logic             h;
        logic             f;
        access(1'b0, a, '0, r, h, f);
        compare_word("data_out", r, exp_data);
        compare_bit("cache_hit", h, exp_hit);
        compare_bit("done in request cycle", f, exp_hit);  // Only a hit skips memory
    endtask

    task automatic write_check(cache_pkg::addr_t a, cache_pkg::word_t d, logic exp_hit);
        cache_pkg::word_t r;
        logic             h;
        logic             f;
        access(1'b1, a, d, r, h, f);
        compare_bit("cache_hit", h, exp_hit);
        compare_bit("done in request cycle", f, exp_hit);
    endtask

    task automatic report_test(string name, int start_errs);
        num_tests++;
        if (errors == start_errs) begin
            clean_tests++;
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - start_errs);
        end
    endtask

    task automatic write_allocate();
        int start_errs;
        start_errs = errors;
        write_check(make_addr(5'd1, 8'h10, 2'd0), 16'h1a2b, 1'b0);  // Cold line
        read_check(make_addr(5'd1, 8'h10, 2'd0), 16'h1a2b, 1'b1);
        report_test("write_allocate", start_errs);
    endtask

    task automatic untouched_words();
        int start_errs;
        start_errs = errors;
        write_check(make_addr(5'd2, 8'h20, 2'd1), 16'hbeef, 1'b0);
        read_check(make_addr(5'd2, 8'h20, 2'd0), 16'h0000, 1'b1);  // Filled from zero memory
        read_check(make_addr(5'd2, 8'h20, 2'd2), 16'h0000, 1'b1);
        read_check(make_addr(5'd2, 8'h20, 2'd3), 16'h0000, 1'b1);
        report_test("untouched_words", start_errs);
    endtask

    task automatic dirty_eviction();
        int start_errs;
        start_errs = errors;
        write_check(make_addr(5'd4, 8'h30, 2'd0), 16'h4444, 1'b0);
        write_check(make_addr(5'd12, 8'h30, 2'd0), 16'hcccc, 1'b0);  // Pushes first line out
        read_check(make_addr(5'd4, 8'h30, 2'd0), 16'h4444, 1'b0);   // Only memory has it now
        read_check(make_addr(5'd12, 8'h30, 2'd0), 16'hcccc, 1'b0);
        report_test("dirty_eviction", start_errs);
    endtask

    task automatic overwrite();
        int start_errs;
        start_errs = errors;
        write_check(make_addr(5'd6, 8'h40, 2'd3), 16'h1111, 1'b0);
        write_check(make_addr(5'd6, 8'h40, 2'd3), 16'h2222, 1'b1);
        read_check(make_addr(5'd6, 8'h40, 2'd3), 16'h2222, 1'b1);
        report_test("overwrite", start_errs);
    endtask

    // 4 tags over indices 0x10 to 0x17
    task automatic random_mix();
        int               start_errs;
        int               r;
        cache_pkg::addr_t a;
        cache_pkg::word_t d;
        start_errs = errors;
        for (int n = 0; n < 60; n++) begin
            r = $random(seed);
            d = cache_pkg::word_t'($random(seed));
            a = make_addr({3'b000, r[1:0]}, {5'b00010, r[4:2]}, r[6:5]);
            if (r[7]) begin
                write_check(a, d, predict_hit(a));
            end else begin
                read_check(a, ref_mem[a[15:1]], predict_hit(a));
            end
        end
        report_test("random_mix", start_errs);
    endtask

    task automatic reset_invalidates();
        int start_errs;
        start_errs = errors;
        write_check(make_addr(5'd3, 8'h60, 2'd2), 16'h5a5a, 1'b0);
        write_check(make_addr(5'd9, 8'h60, 2'd2), 16'ha5a5, 1'b0);  // Victim goes to memory
        read_check(make_addr(5'd3, 8'h60, 2'd2), 16'h5a5a, 1'b0);   // Clean copy back in
        read_check(make_addr(5'd3, 8'h60, 2'd2), 16'h5a5a, 1'b1);
        apply_reset();
        read_check(make_addr(5'd3, 8'h60, 2'd2), 16'h5a5a, 1'b0);
        report_test("reset_invalidates", start_errs);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        addr        = '0;
        data_in     = '0;
        rd          = 1'b0;
        wr          = 1'b0;
        errors      = 0;
        checks      = 0;
        num_tests   = 0;
        clean_tests = 0;
        seed        = 32'hdb26;
        for (int i = 0; i < cache_pkg::MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < cache_pkg::NUM_LINES; i++) begin
            tag_model[i] = '0;
        end
        invalidate_model();
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;

        write_allocate();
        untouched_words();
        dirty_eviction();
        overwrite();
        random_mix();
        reset_invalidates();

        $display("Checks %0d, errors %0d, clean tests %0d of %0d",
                 checks, errors, clean_tests, num_tests);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== hdl/banked_mem.sv ====
module banked_mem (
    input  logic                                 clk,
    input  logic                                 reset,
    input  cache_pkg::addr_t                     mem_addr,
    input  cache_pkg::word_t                     mem_wdata,
    input  logic                                 mem_rd,
    input  logic                                 mem_wr,
    output logic [cache_pkg::WORDS_PER_LINE-1:0] busy,      // One flag per bank
    output logic                                 rd_valid,
    output cache_pkg::word_t                     rd_data
);

    // Word storage, bank is word address bits 1..0
    cache_pkg::word_t mem [cache_pkg::MEM_WORDS];

    cache_pkg::busy_cnt_t             busy_cnt [cache_pkg::WORDS_PER_LINE];
    logic [cache_pkg::MEM_LATENCY-1:0] pipe_v;    // Read valid shift chain
    cache_pkg::word_t                 pipe_d [cache_pkg::MEM_LATENCY];
    cache_pkg::offset_t               bank;
    logic [cache_pkg::ADDR_W-2:0]     word_addr;
    logic                             accept;

    assign bank      = mem_addr[2:1];
    assign word_addr = mem_addr[cache_pkg::ADDR_W-1:1];  // Drop the byte bit
    assign accept    = (mem_rd || mem_wr) && !busy[bank];  // Busy bank ignores strobes

    always_comb begin
        for (int b = 0; b < cache_pkg::WORDS_PER_LINE; b++) begin
            busy[b] = (busy_cnt[b] != '0);
        end
    end

    // Memory starts all zero
    initial begin
        for (int i = 0; i < cache_pkg::MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr && accept) begin
            mem[word_addr] <= mem_wdata;
        end
    end

    // Bank busy counters
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < cache_pkg::WORDS_PER_LINE; b++) begin
                busy_cnt[b] <= '0;
            end
        end else begin
            for (int b = 0; b < cache_pkg::WORDS_PER_LINE; b++) begin
                if (accept && (bank == b[1:0])) begin
                    // Block this bank for the following cycles
                    busy_cnt[b] <= cache_pkg::busy_cnt_t'(cache_pkg::BANK_BUSY_CYCLES);
                end else if (busy_cnt[b] != '0) begin
                    busy_cnt[b] <= busy_cnt[b] - 1'b1;
                end
            end
        end
    end

    // Read valid pipeline, one stage per latency cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pipe_v <= '0;
        end else begin
            pipe_v[0] <= mem_rd && accept;
            for (int i = 1; i < cache_pkg::MEM_LATENCY; i++) begin
                pipe_v[i] <= pipe_v[i-1];
            end
        end
    end

    // Read data travels alongside its valid bit
    always_ff @(posedge clk) begin
        pipe_d[0] <= mem[word_addr];
        for (int i = 1; i < cache_pkg::MEM_LATENCY; i++) begin
            pipe_d[i] <= pipe_d[i-1];
        end
    end

    assign rd_valid = pipe_v[cache_pkg::MEM_LATENCY-1];
    assign rd_data  = pipe_d[cache_pkg::MEM_LATENCY-1];  // Stale unless rd_valid

endmodule

// ==== hdl/cache_array.sv ====
module cache_array (
    input  logic               clk,
    input  logic               reset,
    input  cache_pkg::index_t  line_index,
    input  cache_pkg::offset_t word_offset,
    input  cache_pkg::tag_t    write_tag,
    input  cache_pkg::word_t   write_word,
    input  logic               word_wr,          // One word write at word_offset
    input  logic               line_fill_start,  // New tag, valid set, dirty cleared
    input  logic               set_dirty,
    output cache_pkg::tag_t    stored_tag,
    output logic               line_valid,
    output logic               line_dirty,
    output cache_pkg::word_t   read_word
);

    // Per line state
    cache_pkg::tag_t                  tag_mem [cache_pkg::NUM_LINES];
    logic [cache_pkg::NUM_LINES-1:0]  valid_bits;
    logic [cache_pkg::NUM_LINES-1:0]  dirty_bits;

    // Line data, four words per line laid out contiguously
    cache_pkg::word_t data_mem [cache_pkg::NUM_LINES * cache_pkg::WORDS_PER_LINE];

    logic [cache_pkg::INDEX_W+$bits(cache_pkg::offset_t)-1:0] word_sel;

    assign word_sel = {line_index, word_offset};  // Index and offset form the word address

    // Zero-cycle lookup of the addressed line
    assign stored_tag = tag_mem[line_index];
    assign line_valid = valid_bits[line_index];
    assign line_dirty = dirty_bits[line_index];
    assign read_word  = data_mem[word_sel];

    // Valid and dirty flags
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;  // All lines invalid
            dirty_bits <= '0;
        end else begin
            if (line_fill_start) begin
                valid_bits[line_index] <= 1'b1;
                dirty_bits[line_index] <= 1'b0;  // Fresh copy matches memory
            end
            if (set_dirty) begin
                dirty_bits[line_index] <= 1'b1;
            end
        end
    end

    // Tag store, written once per refill
    always_ff @(posedge clk) begin
        if (line_fill_start) begin
            tag_mem[line_index] <= write_tag;
        end
    end

    // Data store
    always_ff @(posedge clk) begin
        if (word_wr) begin
            data_mem[word_sel] <= write_word;  // Fill word or processor word
        end
    end

endmodule

// ==== hdl/cache_ctrl.sv ====
module cache_ctrl (
    input  logic                                    clk,
    input  logic                                    reset,
    // Processor request, held until done
    input  cache_pkg::addr_t                        addr,
    input  cache_pkg::word_t                        data_in,
    input  logic                                    rd,
    input  logic                                    wr,
    // Array lookup results
    input  cache_pkg::tag_t                         stored_tag,
    input  logic                                    line_valid,
    input  logic                                    line_dirty,
    input  cache_pkg::word_t                        read_word,
    // Memory status
    input  logic [cache_pkg::WORDS_PER_LINE-1:0]    busy,
    input  logic                                    rd_valid,
    input  cache_pkg::word_t                        rd_data,
    // Array controls
    output cache_pkg::index_t                       line_index,
    output cache_pkg::offset_t                      word_offset,
    output cache_pkg::tag_t                         write_tag,
    output cache_pkg::word_t                        write_word,
    output logic                                    word_wr,
    output logic                                    line_fill_start,
    output logic                                    set_dirty,
    // Memory requests
    output cache_pkg::addr_t                        mem_addr,
    output cache_pkg::word_t                        mem_wdata,
    output logic                                    mem_rd,
    output logic                                    mem_wr,
    // Processor status
    output logic                                    done,
    output logic                                    stall,
    output logic                                    cache_hit
);

    cache_pkg::cache_state_e state;
    cache_pkg::cache_state_e nxt_state;

    logic [2:0]         iss_cnt;     // Memory ops issued, bit 2 means all four out
    cache_pkg::offset_t ret_cnt;     // Fill words written back into the array
    cache_pkg::offset_t iss_bank;    // Bank of the next memory op
    cache_pkg::tag_t    req_tag;
    cache_pkg::offset_t req_offset;
    logic               req;
    logic               hit;
    logic               mem_accept;

    // Field split of the held address
    assign req_tag    = addr[15:11];
    assign line_index = addr[10:3];
    assign req_offset = addr[2:1];

    assign iss_bank  = iss_cnt[1:0];       // Word offset equals bank number
    assign req       = rd || wr;
    assign hit       = line_valid && (stored_tag == req_tag);  // Invalid line never hits
    assign write_tag = req_tag;             // Only a fill records a tag
    assign mem_wdata = read_word;           // Victim word at word_offset

    // Memory takes the op when the target bank is free
    assign mem_accept = (mem_rd || mem_wr) && !busy[iss_bank];

    always_comb begin
        nxt_state       = state;
        word_offset     = req_offset;
        write_word      = data_in;
        word_wr         = 1'b0;
        line_fill_start = 1'b0;
        set_dirty       = 1'b0;
        mem_addr        = {req_tag, line_index, iss_bank, 1'b0};  // Refill address
        mem_rd          = 1'b0;
        mem_wr          = 1'b0;
        done            = 1'b0;
        stall           = 1'b0;
        cache_hit       = 1'b0;

        case (state)
            cache_pkg::IDLE: begin
                if (req) begin
                    if (hit) begin
                        // Hit ends in this cycle
                        done      = 1'b1;
                        cache_hit = 1'b1;
                        word_wr   = wr;     // Write hit stores at the edge
                        set_dirty = wr;
                    end else begin
                        stall = 1'b1;
                        if (line_valid && line_dirty) begin
                            nxt_state = cache_pkg::WRITEBACK;
                        end else begin
                            nxt_state = cache_pkg::FILL;
                        end
                    end
                end
            end

            cache_pkg::WRITEBACK: begin
                stall       = 1'b1;
                word_offset = iss_bank;                                // Victim word out
                mem_addr    = {stored_tag, line_index, iss_bank, 1'b0};  // Victim address
                mem_wr      = 1'b1;
                if (mem_accept && (iss_bank == 2'd3)) begin
                    nxt_state = cache_pkg::FILL;  // Last victim word gone
                end
            end

            cache_pkg::FILL: begin
                stall           = 1'b1;
                mem_rd          = !iss_cnt[2];   // Keep issuing until four are out
                word_offset     = ret_cnt;        // Returns come back in issue order
                write_word      = rd_data;
                word_wr         = rd_valid;
                line_fill_start = rd_valid && (ret_cnt == 2'd0);  // Tag and valid with word 0
                if (rd_valid && (ret_cnt == 2'd3)) begin
                    nxt_state = cache_pkg::FINISH;
                end
            end

            cache_pkg::FINISH: begin
                // Line now present, serve as a hit without the hit flag
                done      = 1'b1;
                word_wr   = wr;
                set_dirty = wr;
                nxt_state = cache_pkg::IDLE;
            end

            default: begin
                nxt_state = cache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= cache_pkg::IDLE;
            iss_cnt <= '0;
            ret_cnt <= '0;
        end else begin
            state <= nxt_state;
            case (state)
                cache_pkg::WRITEBACK: begin
                    if (mem_accept) begin
                        // Wrap to zero so the refill starts at word 0
                        iss_cnt <= (iss_bank == 2'd3) ? 3'd0 : iss_cnt + 3'd1;
                    end
                end
                cache_pkg::FILL: begin
                    if (mem_accept) begin
                        iss_cnt <= iss_cnt + 3'd1;
                    end
                    if (rd_valid) begin
                        ret_cnt <= ret_cnt + 2'd1;  // Wraps to 0 after word 3
                    end
                end
                cache_pkg::FINISH: begin
                    iss_cnt <= '0;
                end
                default: begin
                    iss_cnt <= iss_cnt;  // Idle, counters already clear
                end
            endcase
        end
    end

endmodule

// ==== hdl/cache_pkg.sv ====
package cache_pkg;

    // Processor side widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 16;

    // Address split: tag 15..11, index 10..3, word offset 2..1
    localparam int TAG_W          = 5;
    localparam int INDEX_W        = 8;
    localparam int NUM_LINES      = 256;
    localparam int WORDS_PER_LINE = 4;  // Also the bank count

    // Main memory timing
    localparam int MEM_LATENCY      = 2;  // Accepted read to rd_valid
    localparam int BANK_BUSY_CYCLES = 4;  // Bank blocked after any access
    localparam int MEM_WORDS        = 2 ** (ADDR_W - 1);  // 32K words
    localparam int BUSY_CNT_W       = $clog2(BANK_BUSY_CYCLES + 1);

    typedef logic [DATA_W-1:0]                 word_t;
    typedef logic [ADDR_W-1:0]                 addr_t;
    typedef logic [TAG_W-1:0]                  tag_t;
    typedef logic [INDEX_W-1:0]                index_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] offset_t;
    typedef logic [BUSY_CNT_W-1:0]             busy_cnt_t;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,       // Lookup, hits finish here
        WRITEBACK,  // Dirty victim out to memory
        FILL,       // Line refill from memory
        FINISH      // Serve the held request from the new line
    } cache_state_e;

endpackage

// ==== hdl/mem_system.sv ====
module mem_system (
    input  logic             clk,
    input  logic             reset,
    input  cache_pkg::addr_t addr,
    input  cache_pkg::word_t data_in,
    input  logic             rd,
    input  logic             wr,
    output cache_pkg::word_t data_out,
    output logic             done,
    output logic             stall,
    output logic             cache_hit
);

    // Controller to array
    cache_pkg::index_t  line_index;
    cache_pkg::offset_t word_offset;
    cache_pkg::tag_t    write_tag;
    cache_pkg::word_t   write_word;
    logic               word_wr;
    logic               line_fill_start;
    logic               set_dirty;

    // Array to controller
    cache_pkg::tag_t    stored_tag;
    logic               line_valid;
    logic               line_dirty;
    cache_pkg::word_t   read_word;

    // Controller and memory
    cache_pkg::addr_t                     mem_addr;
    cache_pkg::word_t                     mem_wdata;
    logic                                 mem_rd;
    logic                                 mem_wr;
    logic [cache_pkg::WORDS_PER_LINE-1:0] busy;
    logic                                 rd_valid;
    cache_pkg::word_t                     rd_data;

    assign data_out = read_word;  // Valid on a read's done cycle

    cache_ctrl u_cache_ctrl (
        .clk             (clk),
        .reset           (reset),
        .addr            (addr),
        .data_in         (data_in),
        .rd              (rd),
        .wr              (wr),
        .stored_tag      (stored_tag),
        .line_valid      (line_valid),
        .line_dirty      (line_dirty),
        .read_word       (read_word),
        .busy            (busy),
        .rd_valid        (rd_valid),
        .rd_data         (rd_data),
        .line_index      (line_index),
        .word_offset     (word_offset),
        .write_tag       (write_tag),
        .write_word      (write_word),
        .word_wr         (word_wr),
        .line_fill_start (line_fill_start),
        .set_dirty       (set_dirty),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_rd          (mem_rd),
        .mem_wr          (mem_wr),
        .done            (done),
        .stall           (stall),
        .cache_hit       (cache_hit)
    );

    cache_array u_cache_array (
        .clk             (clk),
        .reset           (reset),
        .line_index      (line_index),
        .word_offset     (word_offset),
        .write_tag       (write_tag),
        .write_word      (write_word),
        .word_wr         (word_wr),
        .line_fill_start (line_fill_start),
        .set_dirty       (set_dirty),
        .stored_tag      (stored_tag),
        .line_valid      (line_valid),
        .line_dirty      (line_dirty),
        .read_word       (read_word)
    );

    banked_mem u_banked_mem (
        .clk       (clk),
        .reset     (reset),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .busy      (busy),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

endmodule

// ==== list.f ====
hdl/cache_pkg.sv
hdl/cache_ctrl.sv
hdl/cache_array.sv
hdl/banked_mem.sv
hdl/mem_system.sv
dv/tb_mem_system.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tb_mem_system \
    -f list.f \
    -o tb_mem_system

./obj_dir/tb_mem_system | tee sim.log

if grep -q "test failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
grep -q "test passed" sim.log
echo "Simulation passed"
